// File: verilog/fp_pkg.sv
package fp_pkg;

	//////////////////////////////////////////////////
	// single precision format
	//////////////////////////////////////////////////

	localparam int fp_exp_w = 8;	// exponent bits
	localparam int fp_man_w = 23;	// stored mantissa bits

	localparam logic [31:0] fp_pos_inf = 32'h7F80_0000;	// exp all ones, man zero
	localparam logic [31:0] fp_neg_inf = 32'hFF80_0000;
	localparam logic [31:0] fp_pos_max = 32'h7F7F_FFFF;	// largest finite positive
	localparam logic [31:0] fp_neg_min = 32'hFF7F_FFFF;	// most negative finite

	// tag placed in the mantissa of every generated NaN
	localparam logic [fp_man_w-1:0] fp_nan_man = 23'h00DEAD;

	//////////////////////////////////////////////////
	// float word seen as bits or as fields
	//////////////////////////////////////////////////

	typedef union packed {
		logic [31:0] raw;			// whole word, as stored in memory
		struct packed {
			logic sign;				// 1 means negative
			logic [fp_exp_w-1:0] exp;	// biased by 127, zero for denormals
			logic [fp_man_w-1:0] man;	// fraction without the hidden one
		} fields;
	} fp_word_u;

endpackage

// File: verilog/mem_pkg.sv
package mem_pkg;

	//////////////////////////////////////////////////
	// scratch memory geometry
	//////////////////////////////////////////////////

	localparam int mem_aw = 6;		// word address width
	localparam int mem_depth = 64;	// 2**mem_aw words
	localparam int cnt_w = 7;		// run length, wide enough for a full memory

	//////////////////////////////////////////////////
	// arbiter requester codes
	//////////////////////////////////////////////////

	localparam logic req_host = 1'b0;	// external host port
	localparam logic req_engine = 1'b1;	// summation engine

endpackage

// File: verilog/fp_shifters.sv
`timescale 1ns/1ps

// log shifter, aligns the mantissa with the smaller exponent
module fp_right_shifter (
	input logic [23:0] in,
	input logic [4:0] shamt,
	output logic [23:0] out
);

	logic [23:0] st1, st2, st4, st8;	// outputs of the power of two stages

	assign st1 = shamt[0] ? {1'b0, in[23:1]} : in;
	assign st2 = shamt[1] ? {2'b0, st1[23:2]} : st1;
	assign st4 = shamt[2] ? {4'b0, st2[23:4]} : st2;
	assign st8 = shamt[3] ? {8'b0, st4[23:8]} : st4;
	assign out = shamt[4] ? {16'b0, st8[23:16]} : st8;	// 24 and up empties the word

endmodule

// log shifter, normalizes the sum by its leading zero count
module fp_left_shifter (
	input logic [23:0] in,
	input logic [4:0] shamt,
	output logic [23:0] out
);

	logic [23:0] st1, st2, st4, st8;

	assign st1 = shamt[0] ? {in[22:0], 1'b0} : in;
	assign st2 = shamt[1] ? {st1[21:0], 2'b0} : st1;
	assign st4 = shamt[2] ? {st2[19:0], 4'b0} : st2;
	assign st8 = shamt[3] ? {st4[15:0], 8'b0} : st4;
	assign out = shamt[4] ? {st8[7:0], 16'b0} : st8;

endmodule

// File: verilog/fp_adder.sv
`timescale 1ns/1ps

module fp_adder (
	input fp_pkg::fp_word_u a,
	input fp_pkg::fp_word_u b,
	output fp_pkg::fp_word_u result
);

	logic [7:0] ea, eb;			// exponents
	logic [22:0] ma, mb;		// stored mantissas
	logic ea_z, eb_z;			// exponent is zero
	logic ea_lo, eb_lo;			// exponent is 0 or 1, both mean 2^-126
	logic a_zero, b_zero;		// +0 or -0

	logic [8:0] diff_raw;		// ea - eb with a borrow bit
	logic [8:0] diff;			// magnitude of the exponent gap
	logic [4:0] shamt;			// alignment shift
	logic a_shft;				// a has the smaller exponent
	logic too_far;				// gap too large, smaller operand dropped
	logic [23:0] m_in;			// hidden bit and mantissa of the smaller one
	logic [23:0] m_shft;		// after alignment
	logic [7:0] common_e;		// exponent both operands now share

	logic [23:0] ca, cb;		// signed magnitudes before sign extension
	logic [24:0] a2c, b2c;		// 25-bit two's complement operands
	logic [24:0] pre_sum;
	logic internal_ofl;			// 25-bit add overflowed
	logic exp_inc, exp_dec;
	logic [24:0] shft_sum;		// pre_sum with the overflow bit folded back
	logic [24:0] shft_temp;
	logic [23:0] sum_man;		// unsigned magnitude of the sum

	logic [4:0] lzc;			// leading zeros, 24 when the sum is zero
	logic [4:0] norm_amt;		// lzc unless the exponent is already minimal
	logic [8:0] exp_diff;		// common_e - norm_amt, sign in bit 8
	logic denorm;				// result lands in the denormal range
	logic [4:0] ls_amt;
	logic [23:0] norm_sum;
	logic [7:0] norm_exp;
	logic [22:0] norm_man;
	logic sign_out;

	logic nan, pos_inf, neg_inf;

	//////////////////////////////////////////////////
	// operand decode
	//////////////////////////////////////////////////

	assign ea = a.fields.exp;
	assign eb = b.fields.exp;
	assign ma = a.fields.man;
	assign mb = b.fields.man;
	assign ea_z = ~|ea;
	assign eb_z = ~|eb;
	assign ea_lo = ~|ea[7:1];
	assign eb_lo = ~|eb[7:1];
	assign a_zero = ~|a.raw[30:0];
	assign b_zero = ~|b.raw[30:0];

	//////////////////////////////////////////////////
	// exponent compare and alignment
	//////////////////////////////////////////////////

	assign diff_raw = {1'b0, ea} - {1'b0, eb};
	assign a_shft = diff_raw[8];	// borrow means eb is larger
	assign diff = a_shft ? (~diff_raw + 9'd1) : diff_raw;

	// denormal exponent counts as 1, so one shift less against a zero exponent
	assign shamt = (ea_lo & eb_lo) ? 5'd0 :
			(ea_z | eb_z) ? diff[4:0] - 5'd1 :
			diff[4:0];

	assign m_in = a_shft ? {~ea_z, ma} : {~eb_z, mb};
	assign common_e = a_shft ? eb : ea;

	fp_right_shifter align_i (
		.in(m_in),
		.shamt(shamt),
		.out(m_shft)
	);

	// flush the shifted operand once the gap reaches 23 bits
	assign too_far = ~|m_shft | (|diff[8:5]) | (&diff[4:3]) | (&{diff[4], diff[2:0]});

	//////////////////////////////////////////////////
	// two's complement add
	//////////////////////////////////////////////////

	assign ca = a_shft ? (a.fields.sign ? ~m_shft + 24'd1 : m_shft) :
			(a.fields.sign ? ~{~ea_z, ma} + 24'd1 : {~ea_z, ma});
	assign cb = a_shft ? (b.fields.sign ? ~{~eb_z, mb} + 24'd1 : {~eb_z, mb}) :
			(b.fields.sign ? ~m_shft + 24'd1 : m_shft);

	assign a2c = (a_shft & too_far) ? 25'd0 : {a.fields.sign, ca};
	assign b2c = (~a_shft & too_far) ? 25'd0 : {b.fields.sign, cb};

	assign pre_sum = a2c + b2c;
	// like signs giving an unlike sign
	assign internal_ofl = (~a2c[24] & ~b2c[24] & pre_sum[24]) |
			(a2c[24] & b2c[24] & ~pre_sum[24]);

	assign shft_sum = internal_ofl ? {~pre_sum[24], pre_sum[24:1]} : pre_sum;
	assign shft_temp = ~(shft_sum - 25'd1);	// negate back to a magnitude
	assign sum_man = shft_sum[24] ? shft_temp[23:0] : shft_sum[23:0];

	// carry out of two denormals or two same-sign hidden ones
	assign exp_inc = internal_ofl | (ea_z & eb_z & sum_man[23]) |
			(pre_sum == 25'h100_0000) |
			(~(a2c[24] ^ b2c[24]) & a2c[23] & b2c[23] & ~pre_sum[23] &
			(~|pre_sum[22:0]));
	// exponent 1 drops to denormal
	assign exp_dec = ~internal_ofl & (~|common_e[7:1]) & common_e[0] & ~sum_man[23];

	//////////////////////////////////////////////////
	// normalization
	//////////////////////////////////////////////////

	always_comb begin
		lzc = 5'd24;	// nothing set
		for (int i = 0; i < 24; i++) begin
			if (sum_man[i])
				lzc = 5'(23 - i);	// highest set bit wins, it comes last
		end
	end

	assign norm_amt = (~|common_e[7:1]) ? 5'd0 : lzc;
	assign exp_diff = {1'b0, common_e} - {4'b0, norm_amt};
	assign denorm = exp_diff[8] | (~|exp_diff);
	assign ls_amt = denorm ? common_e[4:0] : norm_amt;	// stop at the minimum exponent

	fp_left_shifter norm_i (
		.in(sum_man),
		.shamt(ls_amt),
		.out(norm_sum)
	);

	assign norm_exp = exp_inc ? common_e + 8'd1 :
			(&norm_amt[4:3]) ? 8'h00 :	// zero sum
			exp_dec ? 8'h00 :
			denorm ? 8'h00 :
			common_e - {3'b0, norm_amt};
	assign norm_man = (denorm & (|norm_amt)) ? norm_sum[23:1] : norm_sum[22:0];
	assign sign_out = internal_ofl ? ~pre_sum[24] : pre_sum[24];

	//////////////////////////////////////////////////
	// special cases, NaN first then infinities then zeros
	//////////////////////////////////////////////////

	assign nan = (a.raw == fp_pkg::fp_pos_inf & b.raw == fp_pkg::fp_neg_inf) |
			(b.raw == fp_pkg::fp_pos_inf & a.raw == fp_pkg::fp_neg_inf) |
			(&ea & |ma) | (&eb & |mb);
	assign pos_inf = (a.raw == fp_pkg::fp_pos_inf & b.raw != fp_pkg::fp_neg_inf) |
			(b.raw == fp_pkg::fp_pos_inf & a.raw != fp_pkg::fp_neg_inf) |
			(a.raw == fp_pkg::fp_pos_max & b.raw == fp_pkg::fp_pos_max) |
			(~sign_out & (&norm_exp));	// exponent overflow
	assign neg_inf = (a.raw == fp_pkg::fp_neg_inf & b.raw != fp_pkg::fp_pos_inf) |
			(b.raw == fp_pkg::fp_neg_inf & a.raw != fp_pkg::fp_pos_inf) |
			(a.raw == fp_pkg::fp_neg_min & b.raw == fp_pkg::fp_neg_min) |
			(sign_out & (&norm_exp));

	assign result.raw = nan ? {sign_out, 8'hFF, fp_pkg::fp_nan_man} :
			neg_inf ? fp_pkg::fp_neg_inf :
			pos_inf ? fp_pkg::fp_pos_inf :
			a_zero ? b.raw :
			b_zero ? a.raw :
			{sign_out, norm_exp, norm_man};

endmodule

// File: verilog/scratch_mem.sv
`timescale 1ns/1ps

module scratch_mem (
	input logic clk,
	input logic en,		// access this cycle
	input logic we,		// write when set, read otherwise
	input logic [mem_pkg::mem_aw-1:0] addr,
	input logic [31:0] wdata,
	output logic [31:0] rdata
);

	logic [31:0] mem [mem_pkg::mem_depth];	// word storage

	//////////////////////////////////////////////////
	// single port, one cycle read
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (en) begin
			if (we)
				mem[addr] <= wdata;	// lands on this edge
			else
				rdata <= mem[addr];	// valid the cycle after
		end
	end

endmodule

// File: verilog/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
	input logic clk,
	input logic arst_n,
	input logic host_wr,
	input logic host_rd,
	input logic [mem_pkg::mem_aw-1:0] host_addr,
	input logic [31:0] host_wdata,
	input logic eng_req,
	input logic eng_we,
	input logic [mem_pkg::mem_aw-1:0] eng_addr,
	input logic [31:0] eng_wdata,
	input logic [31:0] mem_rdata,
	output logic [31:0] host_rdata,
	output logic host_rd_valid,
	output logic eng_gnt,
	output logic [31:0] eng_rdata,
	output logic eng_rvalid,
	output logic mem_en,
	output logic mem_we,
	output logic [mem_pkg::mem_aw-1:0] mem_addr,
	output logic [31:0] mem_wdata
);

	logic host_sel;		// host strobe present, host owns the port
	logic rd_pend;		// a read returns data this cycle
	logic rd_owner;		// who issued that read

	//////////////////////////////////////////////////
	// fixed priority, host always wins
	//////////////////////////////////////////////////

	assign host_sel = host_wr | host_rd;
	assign eng_gnt = eng_req & ~host_sel;	// engine keeps asking until this
	assign mem_en = host_sel | eng_req;
	assign mem_we = host_sel ? host_wr : eng_we;
	assign mem_addr = host_sel ? host_addr : eng_addr;
	assign mem_wdata = host_sel ? host_wdata : eng_wdata;

	// remember the read in flight
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_pend <= 1'b0;
			rd_owner <= mem_pkg::req_host;
		end else begin
			rd_pend <= host_rd | (eng_gnt & ~eng_we);
			rd_owner <= host_rd ? mem_pkg::req_host : mem_pkg::req_engine;
		end
	end

	// route returning data to its owner
	assign host_rd_valid = rd_pend & (rd_owner == mem_pkg::req_host);
	assign eng_rvalid = rd_pend & (rd_owner == mem_pkg::req_engine);
	assign host_rdata = mem_rdata;
	assign eng_rdata = mem_rdata;	// qualified by eng_rvalid

endmodule

// File: verilog/sum_engine.sv
`timescale 1ns/1ps

module sum_engine (
	input logic clk,
	input logic arst_n,
	input logic start,		// one cycle, ignored while busy
	input logic [mem_pkg::mem_aw-1:0] base_addr,
	input logic [mem_pkg::cnt_w-1:0] count,
	input logic [mem_pkg::mem_aw-1:0] result_addr,
	input logic eng_gnt,
	input logic [31:0] eng_rdata,
	input logic eng_rvalid,
	output logic eng_req,
	output logic eng_we,
	output logic [mem_pkg::mem_aw-1:0] eng_addr,
	output logic [31:0] eng_wdata,
	output logic busy,
	output logic done,
	output logic [31:0] sum
);

	logic [mem_pkg::cnt_w-1:0] cnt_q;		// words in this run
	logic [mem_pkg::cnt_w-1:0] iss_cnt;		// reads granted so far
	logic [mem_pkg::cnt_w-1:0] ret_cnt;		// words accumulated so far
	logic [mem_pkg::mem_aw-1:0] base_q, res_q;
	fp_pkg::fp_word_u acc;					// running sum
	fp_pkg::fp_word_u ret_word;				// word coming back from memory
	fp_pkg::fp_word_u add_res;
	logic accept;							// start taken this cycle
	logic issuing;							// reads still to issue
	logic wr_phase;							// all words in, write back

	//////////////////////////////////////////////////
	// request side
	//////////////////////////////////////////////////

	assign accept = start & ~busy & (|count);
	assign issuing = busy & (iss_cnt != cnt_q);
	assign wr_phase = busy & (ret_cnt == cnt_q);	// implies all reads issued
	assign eng_req = issuing | wr_phase;
	assign eng_we = wr_phase;
	assign eng_addr = wr_phase ? res_q : base_q + iss_cnt[mem_pkg::mem_aw-1:0];
	assign eng_wdata = acc.raw;
	assign sum = acc.raw;	// final once done pulses

	assign ret_word.raw = eng_rdata;

	fp_adder add_i (
		.a(acc),		// accumulator feeds back
		.b(ret_word),
		.result(add_res)
	);

	//////////////////////////////////////////////////
	// control
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			done <= 1'b0;
			iss_cnt <= '0;
			ret_cnt <= '0;
		end else begin
			done <= 1'b0;	// pulse
			if (accept) begin
				busy <= 1'b1;
				iss_cnt <= '0;
				ret_cnt <= '0;
			end else if (busy) begin
				if (eng_gnt & issuing)
					iss_cnt <= iss_cnt + 1'b1;	// next address goes out
				if (eng_rvalid)
					ret_cnt <= ret_cnt + 1'b1;
				if (eng_gnt & wr_phase) begin
					busy <= 1'b0;	// sum is in memory
					done <= 1'b1;
				end
			end
		end
	end

	// run parameters and accumulator
	always_ff @(posedge clk) begin
		if (accept) begin
			cnt_q <= count;
			base_q <= base_addr;
			res_q <= result_addr;
			acc.raw <= '0;	// +0
		end else if (eng_rvalid) begin
			acc <= add_res;
		end
	end

endmodule

// File: verilog/fp_sum_top.sv
`timescale 1ns/1ps

module fp_sum_top (
	input logic clk,
	input logic arst_n,
	input logic host_wr,
	input logic host_rd,
	input logic [mem_pkg::mem_aw-1:0] host_addr,
	input logic [31:0] host_wdata,
	output logic [31:0] host_rdata,
	output logic host_rd_valid,
	input logic start,
	input logic [mem_pkg::mem_aw-1:0] base_addr,
	input logic [mem_pkg::cnt_w-1:0] count,
	input logic [mem_pkg::mem_aw-1:0] result_addr,
	output logic busy,
	output logic done,
	output logic [31:0] sum
);

	//////////////////////////////////////////////////
	// engine to arbiter
	//////////////////////////////////////////////////

	logic eng_req, eng_we, eng_gnt, eng_rvalid;
	logic [mem_pkg::mem_aw-1:0] eng_addr;
	logic [31:0] eng_wdata, eng_rdata;

	// arbiter to memory
	logic mem_en, mem_we;
	logic [mem_pkg::mem_aw-1:0] mem_addr;
	logic [31:0] mem_wdata, mem_rdata;

	mem_arbiter mem_arbiter_i (
		.clk(clk), .arst_n(arst_n),
		.host_wr(host_wr), .host_rd(host_rd),
		.host_addr(host_addr), .host_wdata(host_wdata),
		.eng_req(eng_req), .eng_we(eng_we),
		.eng_addr(eng_addr), .eng_wdata(eng_wdata),
		.mem_rdata(mem_rdata),
		.host_rdata(host_rdata), .host_rd_valid(host_rd_valid),
		.eng_gnt(eng_gnt), .eng_rdata(eng_rdata), .eng_rvalid(eng_rvalid),
		.mem_en(mem_en), .mem_we(mem_we),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata)
	);

	scratch_mem scratch_mem_i (
		.clk(clk), .en(mem_en), .we(mem_we),
		.addr(mem_addr), .wdata(mem_wdata), .rdata(mem_rdata)
	);

	sum_engine sum_engine_i (
		.clk(clk), .arst_n(arst_n),
		.start(start), .base_addr(base_addr),
		.count(count), .result_addr(result_addr),
		.eng_gnt(eng_gnt), .eng_rdata(eng_rdata), .eng_rvalid(eng_rvalid),
		.eng_req(eng_req), .eng_we(eng_we),
		.eng_addr(eng_addr), .eng_wdata(eng_wdata),
		.busy(busy), .done(done), .sum(sum)	// done ends the busy period
	);

endmodule

// File: tests/fp_sum_properties.sv
`timescale 1ns/1ps

module fp_sum_properties (
	input logic clk,
	input logic arst_n,
	input logic host_wr,
	input logic host_rd,
	input logic host_rd_valid,
	input logic eng_gnt,
	input logic eng_rvalid,
	input logic busy,
	input logic done
);

	int fail_cnt = 0;	// read by the testbench at the end
	logic owner;		// engine held the grant last cycle

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			owner <= mem_pkg::req_host;
		else
			owner <= eng_gnt ? mem_pkg::req_engine : mem_pkg::req_host;
	end

	//////////////////////////////////////////////////
	// host port and arbiter
	//////////////////////////////////////////////////

	assert property (@(posedge clk) disable iff (!arst_n) host_rd |=> host_rd_valid)
		else begin $error("host read data missing one cycle after the strobe"); fail_cnt++; end

	assert property (@(posedge clk) disable iff (!arst_n) !(eng_gnt && (host_wr || host_rd)))
		else begin $error("engine granted while the host strobes"); fail_cnt++; end

	// returned data goes to the one that asked
	assert property (@(posedge clk) disable iff (!arst_n)
			host_rd_valid |-> owner == mem_pkg::req_host)
		else begin $error("host read valid for an engine read"); fail_cnt++; end
	assert property (@(posedge clk) disable iff (!arst_n)
			eng_rvalid |-> owner == mem_pkg::req_engine)
		else begin $error("engine read valid for a host read"); fail_cnt++; end

	//////////////////////////////////////////////////
	// engine
	//////////////////////////////////////////////////

	assert property (@(posedge clk) disable iff (!arst_n) done |=> !done)
		else begin $error("done longer than one cycle"); fail_cnt++; end
	assert property (@(posedge clk) disable iff (!arst_n) done |-> !busy && $past(busy))
		else begin $error("done outside the end of a busy period"); fail_cnt++; end

	assert property (@(posedge clk) !arst_n |-> !busy && !done)	// held by async reset
		else begin $error("busy or done high during reset"); fail_cnt++; end

endmodule

// File: tests/fp_sum_tb.sv
`timescale 1ns/1ps

module fp_sum_tb;

	//////////////////////////////////////////////////
	// run length budget
	//////////////////////////////////////////////////

	// count plus 3 for every engine run, in test order
	localparam int run_cycles = (8 + 3) + (3 + 3) + (2 + 3) + (2 + 3) + (2 + 3) + (4 + 3) +
			(16 + 3) + (8 + 3);
	// host writes and reads, loads included
	localparam int host_accesses = 16 + 9 + 7 + 6 + 27 + 8;
	localparam int cycle_limit = run_cycles + 2 * host_accesses + 200;

	logic clk, arst_n;
	logic host_wr, host_rd;
	logic [mem_pkg::mem_aw-1:0] host_addr;
	logic [31:0] host_wdata, host_rdata;
	logic host_rd_valid;
	logic start;
	logic [mem_pkg::mem_aw-1:0] base_addr, result_addr;
	logic [mem_pkg::cnt_w-1:0] count;
	logic busy, done;
	logic [31:0] sum;

	int errors = 0;		// failed checks
	int checks = 0;
	int tests = 0;
	int mark_c = 0;		// counts at the start of the current test
	int mark_e = 0;
	int cycles = 0;
	int done_cnt = 0;	// done pulses seen

	fp_sum_top fp_sum_top_i (.*);

	bind fp_sum_top fp_sum_properties props_i (
		.clk(clk), .arst_n(arst_n),
		.host_wr(host_wr), .host_rd(host_rd), .host_rd_valid(host_rd_valid),
		.eng_gnt(eng_gnt), .eng_rvalid(eng_rvalid),
		.busy(busy), .done(done)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;	// 100 ns
	end

	// hard stop
	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Test failures found");
			$finish;
		end
	end

	always @(negedge clk)
		if (done)
			done_cnt++;	// one negedge per pulse

	//////////////////////////////////////////////////
	// checks and reference
	//////////////////////////////////////////////////

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_int(input string name, input int exp, input int act);
		checks++;
		assert (act == exp) else begin
			$display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("%s: %0d checks, %0d failed", name, checks - mark_c, errors - mark_e);
		mark_c = checks;
		mark_e = errors;
	endtask

	function automatic logic [31:0] int_word(input int v);
		shortreal f;
		f = v;	// exact for small integers
		return $shortrealtobits(f);
	endfunction

	// sum in list order, each partial rounded to single
	function automatic logic [31:0] ref_total(input logic [31:0] words [$]);
		shortreal acc;
		acc = 0.0;
		foreach (words[i])
			acc = $bitstoshortreal($shortrealtobits(acc + $bitstoshortreal(words[i])));
		return $shortrealtobits(acc);
	endfunction

	//////////////////////////////////////////////////
	// bus tasks, entered just after a falling edge
	//////////////////////////////////////////////////

	task automatic write_word(input logic [5:0] addr, input logic [31:0] data);
		host_wr = 1'b1;
		host_addr = addr;
		host_wdata = data;
		@(negedge clk);
		host_wr = 1'b0;	// one cycle strobe
	endtask

	task automatic read_back(input string name, input logic [5:0] addr, input logic [31:0] exp);
		host_rd = 1'b1;
		host_addr = addr;
		@(negedge clk);
		host_rd = 1'b0;
		checks++;
		assert (host_rd_valid) else begin
			$display("%s: read data of address %0d not valid one cycle after the strobe",
					name, addr);
			errors++;
		end
		check_word(name, exp, host_rdata);
	endtask

	task automatic load_run(input logic [5:0] base, input logic [31:0] words [$]);
		foreach (words[i])
			write_word(base + 6'(i), words[i]);
	endtask

	// lat counts falling edges from the start strobe to the one that sees done
	task automatic run_sum(input logic [5:0] base, input logic [6:0] n, input logic [5:0] res,
			output logic [31:0] total, output int lat);
		start = 1'b1;
		base_addr = base;
		count = n;
		result_addr = res;
		@(negedge clk);
		start = 1'b0;
		lat = 1;
		while (!done) begin
			@(negedge clk);
			lat++;
		end
		total = sum;
	endtask

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////

	initial begin
		logic [31:0] q [$];
		logic [31:0] total;
		logic [31:0] tw [5];	// host traffic words
		int gap [10];
		int lat;
		int v;
		fp_pkg::fp_word_u res;

		void'($urandom(3344));
		arst_n = 1'b0;
		host_wr = 1'b0;
		host_rd = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		start = 1'b0;
		base_addr = '0;
		count = '0;
		result_addr = '0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);

		// host writes then reads back
		for (int i = 0; i < 8; i++) begin
			q.push_back($urandom);
			write_word(6'(i), q[i]);
		end
		foreach (q[i])
			read_back("host_rw", 6'(i), q[i]);
		end_test("host_rw");

		// eight random integers
		q.delete();
		repeat (8) q.push_back(int_word(int'($urandom_range(80)) - 40));
		load_run(8, q);
		run_sum(8, 8, 20, total, lat);
		check_word("rand_sum", ref_total(q), total);
		check_int("rand_sum latency", 8 + 3, lat);
		read_back("rand_sum", 20, ref_total(q));
		end_test("rand_sum");

		// zero, opposite infinities, cancelling pair
		q = '{32'h0, int_word(int'($urandom_range(1, 50))), 32'h0};
		load_run(24, q);
		run_sum(24, 3, 30, total, lat);
		check_word("special zero", ref_total(q), total);
		q = '{fp_pkg::fp_pos_inf, fp_pkg::fp_neg_inf};
		load_run(32, q);
		run_sum(32, 2, 30, total, lat);
		res.raw = total;
		check_word("special nan exp", 32'hFF, 32'(res.fields.exp));
		check_word("special nan man", 32'(fp_pkg::fp_nan_man), 32'(res.fields.man));
		v = int'($urandom_range(1, 30));
		q = '{int_word(v), int_word(-v)};
		load_run(36, q);
		run_sum(36, 2, 30, total, lat);
		check_word("special cancel", 32'h0, total);	// +0
		end_test("special");

		// overflow to infinity, denormal in a mixed run
		q = '{fp_pkg::fp_pos_max, fp_pkg::fp_pos_max};
		load_run(40, q);
		run_sum(40, 2, 31, total, lat);
		check_word("overflow inf", fp_pkg::fp_pos_inf, total);
		q = '{int_word(3), 32'h8000_0005, int_word(-5), int_word(1)};
		load_run(44, q);
		run_sum(44, 4, 31, total, lat);
		check_word("overflow denorm", ref_total(q), total);
		end_test("overflow");

		// host traffic during a run
		q.delete();
		repeat (16) q.push_back(int_word(int'($urandom_range(60)) - 30));
		load_run(0, q);
		foreach (tw[k])
			tw[k] = $urandom;
		foreach (gap[k])
			gap[k] = (k == 0) ? 1 : int'($urandom_range(2));	// first hit lands while issuing
		fork
			run_sum(0, 16, 62, total, lat);
			for (int k = 0; k < 5; k++) begin
				repeat (gap[2 * k]) @(negedge clk);
				write_word(6'(48 + k), tw[k]);
				repeat (gap[2 * k + 1]) @(negedge clk);
				read_back("traffic", 6'(48 + k), tw[k]);
			end
		join
		check_word("traffic", ref_total(q), total);
		checks++;
		assert (lat > 16 + 3) else begin
			$display("[FAIL] traffic latency: expected above %0d, actual %0d", 16 + 3, lat);
			errors++;
		end
		read_back("traffic", 62, ref_total(q));
		end_test("traffic");

		// start while busy is dropped
		q.delete();
		repeat (8) q.push_back(int_word(int'($urandom_range(40)) - 20));
		load_run(16, q);
		done_cnt = 0;
		start = 1'b1;
		base_addr = 16;
		count = 8;
		result_addr = 63;
		@(negedge clk);
		start = 1'b0;
		repeat (3) @(negedge clk);
		start = 1'b1;	// second run, busy so ignored
		base_addr = 0;
		count = 4;
		@(negedge clk);
		start = 1'b0;
		while (!done)
			@(negedge clk);
		check_word("busy_start", ref_total(q), sum);
		repeat (15) @(negedge clk);
		check_int("busy_start done pulses", 1, done_cnt);
		check_int("busy_start busy after", 0, int'(busy));
		end_test("busy_start");

		$display("%0d tests, %0d checks, %0d failed checks, %0d property failures",
				tests, checks, errors, fp_sum_top_i.props_i.fail_cnt);
		if (errors == 0 && fp_sum_top_i.props_i.fail_cnt == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// File: fp_sum.f
verilog/fp_pkg.sv
verilog/mem_pkg.sv
verilog/fp_shifters.sv
verilog/fp_adder.sv
verilog/scratch_mem.sv
verilog/mem_arbiter.sv
verilog/sum_engine.sv
verilog/fp_sum_top.sv
tests/fp_sum_properties.sv
tests/fp_sum_tb.sv
